//--- hw/fetch_buf.sv
`timescale 1ns/1ps

module fetch_buf
	import ifu_pkg::*;
(
	input  logic clk,
	input  logic resetn,
	input  logic clr_i, // flush, drops every entry
	input  logic wen_i,
	input  fetch_res_t wdata_i,
	input  logic ready_i,
	output fetch_res_t rdata_o,
	output logic valid_o,
	output logic take_o
);
	fetch_res_t mem [BUF_DEPTH];
	logic [BUF_DEPTH-1:0] wptr_q; // one-hot
	logic [BUF_DEPTH-1:0] rptr_q; // one-hot
	logic [BUF_DEPTH:0] cnt_q; // one-hot, bit n set means n entries
	fetch_res_t head;

	always_comb
	begin
		head = mem[0];
		for (int i = 1; i < BUF_DEPTH; i++)
			if (rptr_q[i])
				head = mem[i];
	end

	// nop shown while clearing, nothing can be taken then
	assign rdata_o = clr_i ?
		fetch_res_t'{pc: '0, inst: NOP_INST, jump: 1'b0, illegal: 1'b0, err: FE_OK} : head;
	assign valid_o = ~cnt_q[0] & ~clr_i;
	assign take_o = valid_o & ready_i;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			cnt_q <= (BUF_DEPTH + 1)'(1);
			wptr_q <= BUF_DEPTH'(1);
			rptr_q <= BUF_DEPTH'(1);
		end
		else if (clr_i)
		begin
			cnt_q <= (BUF_DEPTH + 1)'(1);
			wptr_q <= BUF_DEPTH'(1);
			rptr_q <= BUF_DEPTH'(1);
		end
		else
		begin
			if (wen_i && !take_o)
				cnt_q <= {cnt_q[BUF_DEPTH-1:0], cnt_q[BUF_DEPTH]}; // one more
			else if (take_o && !wen_i)
				cnt_q <= {cnt_q[0], cnt_q[BUF_DEPTH:1]}; // one less
			if (wen_i)
				wptr_q <= {wptr_q[BUF_DEPTH-2:0], wptr_q[BUF_DEPTH-1]};
			if (take_o)
				rptr_q <= {rptr_q[BUF_DEPTH-2:0], rptr_q[BUF_DEPTH-1]};
		end
	end

	// payload only, no reset
	for (genvar g = 0; g < BUF_DEPTH; g++)
	begin : g_mem
		always_ff @(posedge clk)
		begin
			if (wen_i && wptr_q[g])
				mem[g] <= wdata_i;
		end
	end

	// fetch_ctrl's outstanding limit is what keeps this from firing
	a_no_overflow: assert property (@(posedge clk) disable iff (!resetn)
		wen_i |-> !cnt_q[BUF_DEPTH])
		else $error("write into full fetch buffer");

endmodule

//--- hw/fetch_bus_if.sv
`timescale 1ns/1ps

// request/response path between fetch control and the wishbone port
interface fetch_bus_if
	import ifu_pkg::*;
();
	logic req_valid; // fetch request offered
	logic [XLEN-1:0] req_addr;
	logic req_ready; // port idle, can take a request
	logic resp_valid; // one pulse per accepted request, in order
	logic [XLEN-1:0] resp_data;
	fetch_err_e resp_err;

	modport ctrl (
		output req_valid, req_addr,
		input  req_ready, resp_valid, resp_data, resp_err
	);

	modport port (
		input  req_valid, req_addr,
		output req_ready, resp_valid, resp_data, resp_err
	);

endinterface

//--- hw/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl
	import ifu_pkg::*;
(
	input  logic clk,
	input  logic resetn,
	input  logic flush_i,
	input  logic [XLEN-1:0] flush_addr_i,
	input  logic take_i, // result left the buffer
	fetch_bus_if.ctrl bus,
	output logic buf_wen_o,
	output fetch_res_t buf_data_o
);
	logic [XLEN-1:0] pc_q; // next fetch address, waiting for issue
	logic pc_vld_q;
	logic [1:0] inflight_q; // accepted by the port, response still due
	logic [1:0] drop_q; // responses from the old path still to swallow
	logic [1:0] outst_q; // issued and not yet taken or dropped
	logic [XLEN-1:0] pcq [BUF_DEPTH]; // addresses of requests in flight
	logic [1:0] pcq_wptr;
	logic [1:0] pcq_rptr;
	logic req_fire;
	logic resp_live; // response goes into the buffer
	logic resp_drop;
	logic cur_vld;
	logic [XLEN-1:0] cur_addr;
	logic [XLEN-1:0] resp_pc;
	logic [XLEN-1:0] next_pc;
	logic pd_jump;
	logic pd_illegal;
	logic [XLEN-1:0] pd_target;

	function automatic logic [1:0] wrap_inc(input logic [1:0] p);
		return (p == 2'(BUF_DEPTH - 1)) ? 2'd0 : p + 2'd1;
	endfunction

	predecode u_predecode (
		.inst_i    (bus.resp_data),
		.pc_i      (resp_pc),
		.jump_o    (pd_jump),
		.target_o  (pd_target),
		.illegal_o (pd_illegal)
	);

	assign req_fire = bus.req_valid & bus.req_ready;
	assign resp_pc = pcq[pcq_rptr];
	assign resp_live = bus.resp_valid & ~flush_i & (drop_q == 2'd0);
	assign resp_drop = bus.resp_valid & (drop_q != 2'd0);
	assign next_pc = pd_jump ? pd_target : resp_pc + XLEN'(4);

	// flush wins, then the address predicted from this response, then the held pc
	assign cur_vld = flush_i | resp_live | pc_vld_q;
	assign cur_addr = flush_i ? flush_addr_i : (resp_live ? next_pc : pc_q);

	assign bus.req_valid = cur_vld & (outst_q < 2'(BUF_DEPTH)); // keeps the buffer from overflowing
	assign bus.req_addr = cur_addr;

	assign buf_wen_o = resp_live;
	assign buf_data_o = '{pc: resp_pc, inst: bus.resp_data, jump: pd_jump,
		illegal: pd_illegal, err: bus.resp_err};

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			pc_q <= RESET_PC;
			pc_vld_q <= 1'b1; // first request right after reset
		end
		else if (req_fire)
			pc_vld_q <= 1'b0;
		else if (cur_vld)
		begin
			pc_q <= cur_addr; // port busy or buffer full, hold it
			pc_vld_q <= 1'b1;
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			inflight_q <= 2'd0;
			drop_q <= 2'd0;
			outst_q <= 2'd0;
		end
		else
		begin
			inflight_q <= inflight_q + {1'b0, req_fire} - {1'b0, bus.resp_valid};
			if (flush_i)
			begin
				// everything still due belongs to the old path, buffer is cleared
				drop_q <= inflight_q - {1'b0, bus.resp_valid};
				outst_q <= inflight_q - {1'b0, bus.resp_valid} + {1'b0, req_fire};
			end
			else
			begin
				drop_q <= drop_q - {1'b0, resp_drop};
				outst_q <= outst_q + {1'b0, req_fire} - {1'b0, take_i} - {1'b0, resp_drop};
			end
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			pcq_wptr <= 2'd0;
			pcq_rptr <= 2'd0;
		end
		else
		begin
			if (req_fire)
				pcq_wptr <= wrap_inc(pcq_wptr);
			if (bus.resp_valid)
				pcq_rptr <= wrap_inc(pcq_rptr); // stale responses pop too
		end
	end

	always_ff @(posedge clk)
	begin
		if (req_fire)
			pcq[pcq_wptr] <= bus.req_addr;
	end

	// the port must never answer more requests than were handed to it
	a_resp_has_req: assert property (@(posedge clk) disable iff (!resetn)
		bus.resp_valid |-> (inflight_q != 2'd0))
		else $error("fetch response without an outstanding request");

endmodule

//--- hw/ifu_pkg.sv
package ifu_pkg;

	localparam int XLEN = 32; // data and address width
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000; // first fetch address
	localparam int BUF_DEPTH = 3; // result buffer entries, also max outstanding fetches
	localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013; // addi x0,x0,0

	// fetch error codes, carried with every result
	typedef enum logic [1:0] {
		FE_OK       = 2'b00,
		FE_MISALIGN = 2'b01, // target not word aligned, no bus cycle made
		FE_BUS      = 2'b10 // wishbone err seen
	} fetch_err_e;

	// major opcodes the predecoder cares about
	typedef enum logic [1:0] {
		OP_OTHER,
		OP_JAL,
		OP_BRANCH,
		OP_JALR
	} op_e;

	// bus port fsm
	typedef enum logic [1:0] {
		PS_IDLE, // ready for a request
		PS_BUS, // classic read cycle running
		PS_RESP // one-cycle response strobe
	} port_state_e;

	// one fetch result as stored in the buffer (68 bits)
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] inst;
		logic jump; // predicted taken
		logic illegal; // low two bits not 2'b11
		fetch_err_e err;
	} fetch_res_t;

endpackage

//--- hw/ifu_top.sv
`timescale 1ns/1ps

module ifu_top
	import ifu_pkg::*;
(
	input  logic clk,
	input  logic resetn,
	input  logic flush_i,
	input  logic [XLEN-1:0] flush_addr_i,
	input  logic [XLEN-1:0] wb_dat_i,
	input  logic wb_ack_i,
	input  logic wb_err_i,
	input  logic res_ready_i,
	output logic wb_cyc_o,
	output logic wb_stb_o,
	output logic [XLEN-1:0] wb_adr_o,
	output logic [XLEN-1:0] res_pc_o,
	output logic [XLEN-1:0] res_inst_o,
	output logic res_jump_o,
	output logic res_illegal_o,
	output logic [1:0] res_err_o,
	output logic res_valid_o
);
	fetch_bus_if bus_if ();

	logic buf_wen;
	fetch_res_t buf_wdata;
	fetch_res_t buf_rdata;
	logic buf_take; // result handed to decode

	fetch_ctrl u_ctrl (
		.clk          (clk),
		.resetn       (resetn),
		.flush_i      (flush_i),
		.flush_addr_i (flush_addr_i),
		.take_i       (buf_take),
		.bus          (bus_if.ctrl),
		.buf_wen_o    (buf_wen),
		.buf_data_o   (buf_wdata)
	);

	wb_fetch_port u_port (
		.clk      (clk),
		.resetn   (resetn),
		.wb_dat_i (wb_dat_i),
		.wb_ack_i (wb_ack_i),
		.wb_err_i (wb_err_i),
		.bus      (bus_if.port),
		.wb_cyc_o (wb_cyc_o),
		.wb_stb_o (wb_stb_o),
		.wb_adr_o (wb_adr_o)
	);

	fetch_buf u_buf (
		.clk     (clk),
		.resetn  (resetn),
		.clr_i   (flush_i), // flush also empties the buffer
		.wen_i   (buf_wen),
		.wdata_i (buf_wdata),
		.ready_i (res_ready_i),
		.rdata_o (buf_rdata),
		.valid_o (res_valid_o),
		.take_o  (buf_take)
	);

	// unpack the head entry onto the result ports
	assign res_pc_o = buf_rdata.pc;
	assign res_inst_o = buf_rdata.inst;
	assign res_jump_o = buf_rdata.jump;
	assign res_illegal_o = buf_rdata.illegal;
	assign res_err_o = buf_rdata.err;

endmodule

//--- hw/predecode.sv
`timescale 1ns/1ps

module predecode
	import ifu_pkg::*;
(
	input  logic [XLEN-1:0] inst_i,
	input  logic [XLEN-1:0] pc_i,
	output logic jump_o,
	output logic [XLEN-1:0] target_o,
	output logic illegal_o
);
	op_e op;
	logic [XLEN-1:0] imm_j; // jal offset, sign extended
	logic [XLEN-1:0] imm_b; // branch offset, sign extended

	always_comb
	begin
		case (inst_i[6:0])
			7'b1101111: op = OP_JAL;
			7'b1100011: op = OP_BRANCH;
			7'b1100111: op = OP_JALR; // needs rs1, never predicted here
			default:    op = OP_OTHER;
		endcase
	end

	assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
		inst_i[30:21], 1'b0};
	assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
		inst_i[11:8], 1'b0};

	// compressed encodings are not supported, so anything without 2'b11 is bad
	assign illegal_o = (inst_i[1:0] != 2'b11);

	// static rule: jal always, branch only when the offset is negative
	assign jump_o = !illegal_o &&
		((op == OP_JAL) || ((op == OP_BRANCH) && inst_i[31]));

	assign target_o = pc_i + ((op == OP_JAL) ? imm_j : imm_b);

endmodule

//--- hw/wb_fetch_port.sv
`timescale 1ns/1ps

module wb_fetch_port
	import ifu_pkg::*;
(
	input  logic clk,
	input  logic resetn,
	input  logic [XLEN-1:0] wb_dat_i,
	input  logic wb_ack_i,
	input  logic wb_err_i,
	fetch_bus_if.port bus,
	output logic wb_cyc_o,
	output logic wb_stb_o,
	output logic [XLEN-1:0] wb_adr_o
);
	port_state_e state_q;
	logic [XLEN-1:0] adr_q; // held for the whole cycle
	logic [XLEN-1:0] data_q;
	fetch_err_e err_q;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			state_q <= PS_IDLE;
		else
		begin
			case (state_q)
				PS_IDLE:
					if (bus.req_valid)
						state_q <= (bus.req_addr[1:0] != 2'b00) ? PS_RESP : PS_BUS;
				PS_BUS:
					if (wb_ack_i || wb_err_i)
						state_q <= PS_RESP; // cycle ends on this edge
				default:
					state_q <= PS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if ((state_q == PS_IDLE) && bus.req_valid)
		begin
			adr_q <= bus.req_addr;
			data_q <= NOP_INST; // only kept for a misaligned target
			err_q <= (bus.req_addr[1:0] != 2'b00) ? FE_MISALIGN : FE_OK;
		end
		else if ((state_q == PS_BUS) && (wb_ack_i || wb_err_i))
		begin
			data_q <= wb_ack_i ? wb_dat_i : NOP_INST; // no jump predicted off a faulted word
			err_q <= wb_ack_i ? FE_OK : FE_BUS;
		end
	end

	assign bus.req_ready = (state_q == PS_IDLE);
	assign bus.resp_valid = (state_q == PS_RESP);
	assign bus.resp_data = data_q;
	assign bus.resp_err = err_q;

	assign wb_cyc_o = (state_q == PS_BUS);
	assign wb_stb_o = (state_q == PS_BUS);
	assign wb_adr_o = adr_q;

	// slave may only answer a strobe inside a running cycle
	a_ans_in_cyc: assert property (@(posedge clk) disable iff (!resetn)
		(wb_ack_i || wb_err_i) |-> (wb_cyc_o && wb_stb_o))
		else $error("wishbone ack/err seen outside a cycle");

	// one answer per cycle, never both
	a_ack_err_excl: assert property (@(posedge clk) disable iff (!resetn)
		!(wb_ack_i && wb_err_i))
		else $error("wishbone ack and err in the same cycle");

endmodule

//--- project.f
hw/ifu_pkg.sv
hw/fetch_bus_if.sv
hw/predecode.sv
hw/fetch_ctrl.sv
hw/wb_fetch_port.sv
hw/fetch_buf.sv
hw/ifu_top.sv
tests/ifu_tb.sv

//--- tests/ifu_tb.sv
`timescale 1ns/1ps

module ifu_tb
	import ifu_pkg::*;
();
	localparam int ERR_BASE = 'h20; // error set: count, then byte addresses
	localparam int FLUSH_BASE = 'h28; // flush count, then cycle/address pairs
	localparam int END_BASE = 'h38; // stop pc, expected results on the last path

	logic clk;
	logic resetn;
	logic flush_i;
	logic [31:0] flush_addr_i;
	logic [31:0] wb_dat_i;
	logic wb_ack_i;
	logic wb_err_i;
	logic res_ready_i;
	logic wb_cyc_o;
	logic wb_stb_o;
	logic [31:0] wb_adr_o;
	logic [31:0] res_pc_o;
	logic [31:0] res_inst_o;
	logic res_jump_o;
	logic res_illegal_o;
	logic [1:0] res_err_o;
	logic res_valid_o;

	logic [31:0] tdata [0:63]; // memory image in words 0..31
	logic [31:0] exp_pc; // reference model next pc
	logic [31:0] stop_pc;
	logic bus_busy = 1'b0; // slave inside a classic cycle
	logic done = 1'b0;
	logic timed_out = 1'b0;
	int bus_wait = 0;
	int cycle = 0;
	int limit = 0;
	int nflush = 0;
	int flush_idx = 0;
	int taken_cnt = 0;
	int path_cnt = 0; // results since the last flush
	int exp_cnt = 0;
	int err_cnt = 0;
	int bus_cycles = 0;

	ifu_top DUT (
		.clk           (clk),
		.resetn        (resetn),
		.flush_i       (flush_i),
		.flush_addr_i  (flush_addr_i),
		.wb_dat_i      (wb_dat_i),
		.wb_ack_i      (wb_ack_i),
		.wb_err_i      (wb_err_i),
		.res_ready_i   (res_ready_i),
		.wb_cyc_o      (wb_cyc_o),
		.wb_stb_o      (wb_stb_o),
		.wb_adr_o      (wb_adr_o),
		.res_pc_o      (res_pc_o),
		.res_inst_o    (res_inst_o),
		.res_jump_o    (res_jump_o),
		.res_illegal_o (res_illegal_o),
		.res_err_o     (res_err_o),
		.res_valid_o   (res_valid_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic is_err_addr(input logic [31:0] a);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < tdata[ERR_BASE]; i++)
			if (tdata[ERR_BASE + 1 + i] == a)
				hit = 1'b1;
		return hit;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp_v);
		$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp_v);
		err_cnt++;
	endtask

	// expected fields from the word at exp_pc, then step the model
	task automatic check_result();
		logic [31:0] w;
		logic [1:0] e_err;
		logic e_ill;
		logic e_jmp;
		logic [31:0] tgt;
		if (exp_pc[1:0] != 2'b00)
		begin
			w = NOP_INST; // no bus cycle for it
			e_err = FE_MISALIGN;
		end
		else if (is_err_addr(exp_pc))
		begin
			w = NOP_INST;
			e_err = FE_BUS;
		end
		else
		begin
			w = tdata[exp_pc[6:2]];
			e_err = FE_OK;
		end
		e_ill = (w[1:0] != 2'b11);
		e_jmp = !e_ill && ((w[6:0] == 7'b1101111) || ((w[6:0] == 7'b1100011) && w[31]));
		if (w[6:0] == 7'b1101111)
			tgt = exp_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0}; // j-type
		else
			tgt = exp_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0}; // b-type
		if (res_pc_o !== exp_pc)
			report_mismatch("res_pc_o", res_pc_o, exp_pc);
		if (res_inst_o !== w)
			report_mismatch("res_inst_o", res_inst_o, w);
		if (res_jump_o !== e_jmp)
			report_mismatch("res_jump_o", res_jump_o, e_jmp);
		if (res_illegal_o !== e_ill)
			report_mismatch("res_illegal_o", res_illegal_o, e_ill);
		if (res_err_o !== e_err)
			report_mismatch("res_err_o", res_err_o, e_err);
		taken_cnt++;
		path_cnt++;
		if ((flush_idx == nflush) && (res_pc_o === stop_pc))
			done = 1'b1; // final path reached its spin loop
		exp_pc = e_jmp ? tgt : exp_pc + 32'd4;
	endtask

	// wishbone slave, ack or err after 0 to 2 wait cycles
	task automatic drive_bus();
		wb_ack_i = 1'b0;
		wb_err_i = 1'b0;
		if (wb_cyc_o && wb_stb_o)
		begin
			if (!bus_busy)
			begin
				bus_busy = 1'b1;
				bus_wait = $urandom_range(2, 0);
				bus_cycles++;
				if (wb_adr_o[1:0] != 2'b00)
				begin
					$display("bus cycle started for misaligned address %h at %0t",
						wb_adr_o, $time);
					err_cnt++;
				end
			end
			if (bus_wait == 0)
			begin
				wb_dat_i = tdata[wb_adr_o[6:2]];
				if (is_err_addr(wb_adr_o))
					wb_err_i = 1'b1;
				else
					wb_ack_i = 1'b1;
				bus_busy = 1'b0; // cycle ends on the next edge
			end
			else
				bus_wait--;
		end
	endtask

	task automatic drive_flush();
		flush_i = 1'b0;
		if ((flush_idx < nflush) && (cycle == tdata[FLUSH_BASE + 1 + 2 * flush_idx]))
		begin
			flush_i = 1'b1;
			flush_addr_i = tdata[FLUSH_BASE + 2 + 2 * flush_idx];
			flush_idx++;
		end
	endtask

	initial
	begin
		resetn = 1'b0;
		flush_i = 1'b0;
		flush_addr_i = '0;
		wb_dat_i = '0;
		wb_ack_i = 1'b0;
		wb_err_i = 1'b0;
		res_ready_i = 1'b0;
		void'($urandom(32'habce2c2c));
		$readmemh("tests/ifu_tests.txt", tdata);
		nflush = tdata[FLUSH_BASE];
		stop_pc = tdata[END_BASE];
		exp_cnt = tdata[END_BASE + 1];
		limit = exp_cnt * 40;
		if (nflush > 0)
			limit = limit + tdata[FLUSH_BASE + 2 * nflush - 1]; // last flush cycle
		exp_pc = RESET_PC;
		repeat (3) @(posedge clk);
		#1 resetn = 1'b1;
		while (!done && !timed_out)
		begin
			@(posedge clk);
			cycle++;
			if (res_valid_o && res_ready_i)
				check_result();
			if (flush_i)
			begin
				exp_pc = flush_addr_i; // old path gone from here on
				path_cnt = 0;
			end
			if (!done && (cycle >= limit))
			begin
				$display("timeout: stop address %h not reached after %0d cycles",
					stop_pc, cycle);
				err_cnt++;
				timed_out = 1'b1;
			end
			#1;
			drive_bus();
			res_ready_i = (($urandom % 5) < 3); // decode stalls now and then
			drive_flush();
		end
		if (path_cnt != exp_cnt)
			report_mismatch("final_count", path_cnt, exp_cnt);
		$display("results %0d, final path %0d of %0d, bus cycles %0d, errors %0d",
			taken_cnt, path_cnt, exp_cnt, bus_cycles, err_cnt);
		if (err_cnt == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- tests/ifu_tests.txt
// words 0..31 memory image from byte address 0, eight words per line
// @20 error set (count, byte addresses), @28 flushes (count, cycle, address), @38 stop pc, count
@00
00108093 00000463 00000000 0100006f 00000013 00000013 00000013 00108093
00108093 fe000ce3 00000013 00000013 00000013 00000013 00000013 00000013
00108093 0080006f 00000000 00000463 12345678 00c0006f 00108093 0000006f
ff9ff06f 00000013 00000013 00000013 00000013 00000013 00000013 00000013
// error set
@20
00000002 00000020 00000058
// flushes, misaligned target first, then the final path
@28
00000002
0000003c 00000042
0000005a 00000040
// stop pc, results expected from the last flush up to it
@38
0000005c 00000008
